// File: Bender.yml
package:
  name: ice

sources:
  - logic/ice_pkg.sv
  - logic/uart_loader.sv
  - logic/uart_tx.sv
  - logic/code_arbiter.sv
  - logic/cpu_sequencer.sv
  - logic/cpu_datapath.sv
  - logic/ice_top.sv
  - target: simulation
    files:
      - sim/ice_checker.sv
      - sim/tb_ice.sv

// File: list.f
logic/ice_pkg.sv
logic/uart_loader.sv
logic/uart_tx.sv
logic/code_arbiter.sv
logic/cpu_sequencer.sv
logic/cpu_datapath.sv
logic/ice_top.sv
sim/ice_checker.sv
sim/tb_ice.sv

// File: logic/code_arbiter.sv
`timescale 1ns/1ps

module code_arbiter (
   input  logic               i_clk,
   input  logic               i_nrst,
   input  logic               i_load_done,
   input  ice_pkg::code_req_t i_loader_req,
   input  ice_pkg::code_req_t i_core_req,
   output ice_pkg::code_req_t o_code_req,
   output logic               o_core_gnt
);

   ////////////////////////////////////////
   // grant

   // loader owns the port until the image is in, core keeps it after that
   always_ff @(posedge i_clk or negedge i_nrst) begin
      if (!i_nrst) begin
         o_core_gnt <= 1'b0;
      end else if (i_load_done) begin
         o_core_gnt <= 1'b1;   // sticky
      end
   end

   assign o_code_req = o_core_gnt ? i_core_req : i_loader_req;

endmodule

// File: logic/cpu_datapath.sv
`timescale 1ns/1ps

module cpu_datapath (
   input  logic            i_clk,
   input  logic            i_nrst,
   input  ice_pkg::instr_t i_instr,
   input  logic            i_exec,
   input  logic            i_tx_busy,
   output logic            o_acc_zero,
   output logic            o_carry,
   output logic            o_tx_start,
   output logic [7:0]      o_tx_data
);

   logic [7:0]  op;
   logic [7:0]  imm;
   logic [7:0]  acc;
   logic [7:0]  acc_next;
   logic        carry;
   logic        carry_next;
   logic [15:0] dptr;
   logic [15:0] dptr_next;
   logic [7:0]  rbank [8];
   logic [7:0]  r_sel;
   logic [7:0]  r_next;
   logic        r_wr;
   logic [7:0]  src;
   logic [8:0]  diff;

   assign op    = i_instr.op;
   assign imm   = i_instr.opd1;
   assign r_sel = rbank[op[2:0]];
   assign src   = op[3] ? r_sel : imm;   // add/subb rn forms have bit 3 set
   assign diff  = {1'b0, acc} - {1'b0, src} - {8'd0, carry};   // bit 8 is borrow

   ////////////////////////////////////////
   // execute

   always_comb begin
      acc_next   = acc;
      carry_next = carry;
      dptr_next  = dptr;
      r_wr       = 1'b0;
      r_next     = r_sel;
      if (i_exec) begin
         if (op == ice_pkg::OP_MOVAI) begin
            acc_next = imm;
         end else if (ice_pkg::is_rform(op, ice_pkg::OP_MOVRI)) begin
            r_wr   = 1'b1;
            r_next = imm;
         end else if (ice_pkg::is_rform(op, ice_pkg::OP_MOVAR)) begin
            acc_next = r_sel;
         end else if (ice_pkg::is_rform(op, ice_pkg::OP_MOVRA)) begin
            r_wr   = 1'b1;
            r_next = acc;
         end else if (op == ice_pkg::OP_ADDAI || ice_pkg::is_rform(op, ice_pkg::OP_ADDAR)) begin
            acc_next = acc + src;   // carry untouched
         end else if (op == ice_pkg::OP_SUBBAI || ice_pkg::is_rform(op, ice_pkg::OP_SUBBAR)) begin
            acc_next   = diff[7:0];
            carry_next = diff[8];
         end else if (op == ice_pkg::OP_XRLAI) begin
            acc_next = acc ^ imm;
         end else if (ice_pkg::is_rform(op, ice_pkg::OP_INCR)) begin
            r_wr   = 1'b1;
            r_next = r_sel + 8'd1;
         end else if (op == ice_pkg::OP_DECA) begin
            acc_next = acc - 8'd1;
         end else if (op == ice_pkg::OP_CLRA) begin
            acc_next = 8'h00;
         end else if (op == ice_pkg::OP_CLRC) begin
            carry_next = 1'b0;
         end else if (op == ice_pkg::OP_RLC) begin
            acc_next   = {acc[6:0], carry};
            carry_next = acc[7];
         end else if (op == ice_pkg::OP_MOVDP) begin
            dptr_next = {imm, i_instr.opd2};   // high byte first
         end else if (op == ice_pkg::OP_MOVXAD) begin
            // only the status address is mapped for reads
            acc_next = {7'd0, i_tx_busy & (dptr == ice_pkg::TX_STAT_ADDR)};
         end
      end
   end

   always_ff @(posedge i_clk or negedge i_nrst) begin
      if (!i_nrst) begin
         acc   <= '0;
         carry <= 1'b0;
         dptr  <= '0;
      end else begin
         acc   <= acc_next;
         carry <= carry_next;
         dptr  <= dptr_next;
      end
   end

   always_ff @(posedge i_clk) begin
      if (r_wr) rbank[op[2:0]] <= r_next;
   end

   assign o_acc_zero = (acc == 8'h00);
   assign o_carry    = carry;
   assign o_tx_start = i_exec & (op == ice_pkg::OP_MOVXDA) & (dptr == ice_pkg::TX_DATA_ADDR);
   assign o_tx_data  = acc;

endmodule

// File: logic/cpu_sequencer.sv
`timescale 1ns/1ps

module cpu_sequencer (
   input  logic               i_clk,
   input  logic               i_nrst,
   input  logic               i_gnt,
   input  logic [7:0]         i_code_data,
   input  logic               i_acc_zero,
   input  logic               i_carry,
   output ice_pkg::code_req_t o_code_req,
   output ice_pkg::instr_t    o_instr,
   output logic               o_exec
);

   ice_pkg::cpu_state_e state;
   ice_pkg::cpu_state_e state_next;
   ice_pkg::code_addr_t pc;   // next code byte to read
   logic [7:0]          op_cur;
   logic [1:0]          n_opd;
   logic                pc_step;
   logic                taken;

   // opcode comes straight off the bus in DECODE0, latched afterwards
   assign op_cur = (state == ice_pkg::DECODE0) ? i_code_data : o_instr.op;

   always_comb begin
      case (op_cur)
         ice_pkg::OP_MOVDP: n_opd = 2'd2;
         ice_pkg::OP_MOVAI, ice_pkg::OP_ADDAI, ice_pkg::OP_SUBBAI, ice_pkg::OP_XRLAI,
         ice_pkg::OP_SJMP, ice_pkg::OP_JZ, ice_pkg::OP_JNZ, ice_pkg::OP_JC,
         ice_pkg::OP_JNC:   n_opd = 2'd1;
         default:           n_opd = ice_pkg::is_rform(op_cur, ice_pkg::OP_MOVRI) ? 2'd1 : 2'd0;
      endcase
   end

   always_comb begin
      case (o_instr.op)
         ice_pkg::OP_SJMP: taken = 1'b1;
         ice_pkg::OP_JZ:   taken = i_acc_zero;
         ice_pkg::OP_JNZ:  taken = ~i_acc_zero;
         ice_pkg::OP_JC:   taken = i_carry;
         ice_pkg::OP_JNC:  taken = ~i_carry;
         default:          taken = 1'b0;
      endcase
   end

   ////////////////////////////////////////
   // fsm and pc

   always_comb begin
      case (state)
         ice_pkg::FETCH:   state_next = i_gnt ? ice_pkg::DECODE0 : ice_pkg::FETCH;
         ice_pkg::DECODE0: state_next = (n_opd != 2'd0) ? ice_pkg::DECODE1 : ice_pkg::EXECUTE;
         ice_pkg::DECODE1: state_next = (n_opd == 2'd2) ? ice_pkg::DECODE2 : ice_pkg::EXECUTE;
         ice_pkg::DECODE2: state_next = ice_pkg::EXECUTE;
         default:          state_next = ice_pkg::FETCH;
      endcase
   end

   // one step per byte issued on the bus
   assign pc_step = ((state == ice_pkg::FETCH) & i_gnt) |
                    ((state == ice_pkg::DECODE0) & (n_opd != 2'd0)) |
                    ((state == ice_pkg::DECODE1) & (n_opd == 2'd2));

   always_ff @(posedge i_clk or negedge i_nrst) begin
      if (!i_nrst) begin
         state <= ice_pkg::FETCH;
         pc    <= '0;
      end else begin
         state <= state_next;
         if ((state == ice_pkg::EXECUTE) && taken) begin
            // pc already points past the jump here
            pc <= pc + {{(ice_pkg::CODE_AW-8){o_instr.opd1[7]}}, o_instr.opd1};
         end else if (pc_step) begin
            pc <= pc + 1'b1;
         end
      end
   end

   always_ff @(posedge i_clk) begin
      case (state)
         ice_pkg::DECODE0: o_instr.op   <= i_code_data;
         ice_pkg::DECODE1: o_instr.opd1 <= i_code_data;
         ice_pkg::DECODE2: o_instr.opd2 <= i_code_data;
         default: ;
      endcase
   end

   assign o_exec     = (state == ice_pkg::EXECUTE);
   assign o_code_req = '{wr: 1'b0, addr: pc, data: 8'h00};   // read only

endmodule

// File: logic/ice_pkg.sv
package ice_pkg;

   ////////////////////////////////////////
   // sizes and addresses

   localparam int BIT_CLKS   = 16;   // clocks per uart bit, short for sim
   localparam int LOAD_BYTES = 32;   // program image length
   localparam int CODE_AW    = 9;

   localparam logic [15:0] TX_DATA_ADDR = 16'h0201;
   localparam logic [15:0] TX_STAT_ADDR = 16'h0200;   // busy in bit 0

   ////////////////////////////////////////
   // opcodes

   // register forms carry rn in bits 2:0
   localparam logic [7:0] OP_INCR   = 8'h08;
   localparam logic [7:0] OP_DECA   = 8'h14;
   localparam logic [7:0] OP_ADDAI  = 8'h24;
   localparam logic [7:0] OP_ADDAR  = 8'h28;
   localparam logic [7:0] OP_RLC    = 8'h33;
   localparam logic [7:0] OP_JC     = 8'h40;
   localparam logic [7:0] OP_JNC    = 8'h50;
   localparam logic [7:0] OP_JZ     = 8'h60;
   localparam logic [7:0] OP_XRLAI  = 8'h64;
   localparam logic [7:0] OP_JNZ    = 8'h70;
   localparam logic [7:0] OP_MOVAI  = 8'h74;
   localparam logic [7:0] OP_MOVRI  = 8'h78;
   localparam logic [7:0] OP_SJMP   = 8'h80;
   localparam logic [7:0] OP_MOVDP  = 8'h90;   // mov dptr, #hi, #lo
   localparam logic [7:0] OP_SUBBAI = 8'h94;
   localparam logic [7:0] OP_SUBBAR = 8'h98;
   localparam logic [7:0] OP_CLRC   = 8'hC3;
   localparam logic [7:0] OP_MOVXAD = 8'hE0;   // movx a, @dptr
   localparam logic [7:0] OP_CLRA   = 8'hE4;
   localparam logic [7:0] OP_MOVAR  = 8'hE8;
   localparam logic [7:0] OP_MOVXDA = 8'hF0;   // movx @dptr, a
   localparam logic [7:0] OP_MOVRA  = 8'hF8;

   ////////////////////////////////////////
   // types

   typedef enum logic [2:0] {
      FETCH,
      DECODE0,
      DECODE1,
      DECODE2,
      EXECUTE
   } cpu_state_e;

   typedef logic [CODE_AW-1:0]               code_addr_t;
   typedef logic [$clog2(BIT_CLKS)-1:0]      bit_cnt_t;
   typedef logic [$clog2(LOAD_BYTES+1)-1:0]  load_cnt_t;

   typedef struct packed {
      logic       wr;
      code_addr_t addr;
      logic [7:0] data;
   } code_req_t;

   typedef struct packed {
      logic [7:0] op;
      logic [7:0] opd1;   // first operand byte
      logic [7:0] opd2;
   } instr_t;

   // match an rn form against its base opcode
   function automatic logic is_rform(input logic [7:0] op, input logic [7:0] base);
      return op[7:3] == base[7:3];
   endfunction

endpackage

// File: logic/ice_top.sv
`timescale 1ns/1ps

module ice_top (
   input  logic                        i_clk,
   input  logic                        i_nrst,
   input  logic                        i_uart_rx,
   input  logic [7:0]                  i_code_data,
   output logic                        o_uart_tx,
   output logic                        o_code_wr,
   output logic [ice_pkg::CODE_AW-1:0] o_code_addr,
   output logic [7:0]                  o_code_data
);

   ice_pkg::code_req_t loader_req;
   ice_pkg::code_req_t core_req;
   ice_pkg::code_req_t code_req;   // to the external memory
   ice_pkg::instr_t    instr;
   logic               load_done;
   logic               core_gnt;
   logic               exec;
   logic               acc_zero;
   logic               carry;
   logic               tx_start;
   logic               tx_busy;
   logic [7:0]         tx_data;

   ////////////////////////////////////////
   // code port

   uart_loader i_loader (
      .i_clk(i_clk), .i_nrst(i_nrst), .i_uart_rx(i_uart_rx),
      .o_code_req(loader_req), .o_load_done(load_done)
   );

   code_arbiter i_arbiter (
      .i_clk(i_clk), .i_nrst(i_nrst), .i_load_done(load_done),
      .i_loader_req(loader_req), .i_core_req(core_req),
      .o_code_req(code_req), .o_core_gnt(core_gnt)
   );

   assign o_code_wr   = code_req.wr;
   assign o_code_addr = code_req.addr;
   assign o_code_data = code_req.data;

   ////////////////////////////////////////
   // core and transmitter

   cpu_sequencer i_sequencer (
      .i_clk(i_clk), .i_nrst(i_nrst), .i_gnt(core_gnt), .i_code_data(i_code_data),
      .i_acc_zero(acc_zero), .i_carry(carry),
      .o_code_req(core_req), .o_instr(instr), .o_exec(exec)
   );

   cpu_datapath i_datapath (
      .i_clk(i_clk), .i_nrst(i_nrst), .i_instr(instr), .i_exec(exec), .i_tx_busy(tx_busy),
      .o_acc_zero(acc_zero), .o_carry(carry), .o_tx_start(tx_start), .o_tx_data(tx_data)
   );

   uart_tx i_uart_tx (
      .i_clk(i_clk), .i_nrst(i_nrst), .i_start(tx_start), .i_data(tx_data),
      .o_busy(tx_busy), .o_uart_tx(o_uart_tx)
   );

endmodule

// File: logic/uart_loader.sv
`timescale 1ns/1ps

module uart_loader (
   input  logic                i_clk,
   input  logic                i_nrst,
   input  logic                i_uart_rx,
   output ice_pkg::code_req_t  o_code_req,
   output logic                o_load_done
);

   typedef enum logic [1:0] {RX_IDLE, RX_START, RX_DATA, RX_STOP} rx_state_e;

   rx_state_e           state;
   logic [1:0]          rx_sync;
   logic                rx;
   ice_pkg::bit_cnt_t   cnt;
   logic                half_tick;
   logic                full_tick;
   logic [7:0]          shreg;
   ice_pkg::load_cnt_t  byte_cnt;
   logic                take;
   logic                wr;
   ice_pkg::code_addr_t wr_addr;
   logic [7:0]          wr_data;

   assign rx        = rx_sync[1];
   assign half_tick = (cnt == ice_pkg::bit_cnt_t'(ice_pkg::BIT_CLKS/2 - 1));
   assign full_tick = (cnt == ice_pkg::bit_cnt_t'(ice_pkg::BIT_CLKS - 1));

   // good stop bit and image not yet full
   assign take = (state == RX_STOP) & full_tick & rx &
                 (byte_cnt != ice_pkg::load_cnt_t'(ice_pkg::LOAD_BYTES));

   ////////////////////////////////////////
   // frame state

   always_ff @(posedge i_clk or negedge i_nrst) begin
      if (!i_nrst) begin
         rx_sync <= 2'b11;   // line idles high
         state   <= RX_IDLE;
         cnt     <= '0;
      end else begin
         rx_sync <= {rx_sync[0], i_uart_rx};
         case (state)
            RX_IDLE: begin
               cnt <= '0;
               if (!rx) state <= RX_START;
            end
            RX_START: begin
               cnt <= half_tick ? '0 : cnt + 1'b1;
               if (half_tick) state <= rx ? RX_IDLE : RX_DATA;   // short glitch, back to idle
            end
            RX_DATA: begin
               cnt <= full_tick ? '0 : cnt + 1'b1;
               if (full_tick && shreg[0]) state <= RX_STOP;   // sentinel reached bit 0
            end
            RX_STOP: begin
               cnt <= full_tick ? '0 : cnt + 1'b1;
               if (full_tick) state <= RX_IDLE;
            end
            default: state <= RX_IDLE;
         endcase
      end
   end

   // lsb arrives first, marker bit drops out after 8 samples
   always_ff @(posedge i_clk) begin
      if (state == RX_START && half_tick) shreg <= 8'h80;
      else if (state == RX_DATA && full_tick) shreg <= {rx, shreg[7:1]};
   end

   ////////////////////////////////////////
   // code writes

   always_ff @(posedge i_clk or negedge i_nrst) begin
      if (!i_nrst) begin
         byte_cnt    <= '0;
         wr          <= 1'b0;
         o_load_done <= 1'b0;
      end else begin
         wr <= take;
         if (take) byte_cnt <= byte_cnt + 1'b1;
         if (byte_cnt == ice_pkg::load_cnt_t'(ice_pkg::LOAD_BYTES)) o_load_done <= 1'b1;
      end
   end

   always_ff @(posedge i_clk) begin
      if (take) begin
         wr_addr <= ice_pkg::code_addr_t'(byte_cnt);   // byte index
         wr_data <= shreg;
      end
   end

   assign o_code_req = '{wr: wr, addr: wr_addr, data: wr_data};

endmodule

// File: logic/uart_tx.sv
`timescale 1ns/1ps

module uart_tx (
   input  logic       i_clk,
   input  logic       i_nrst,
   input  logic       i_start,
   input  logic [7:0] i_data,
   output logic       o_busy,
   output logic       o_uart_tx
);

   typedef enum logic [1:0] {TX_IDLE, TX_START, TX_SEND} tx_state_e;

   tx_state_e         state;
   ice_pkg::bit_cnt_t cnt;
   logic [3:0]        bit_cnt;   // 8 data bits then stop
   logic [8:0]        shreg;
   logic              tick;

   assign tick = (cnt == ice_pkg::bit_cnt_t'(ice_pkg::BIT_CLKS - 1));

   always_ff @(posedge i_clk or negedge i_nrst) begin
      if (!i_nrst) begin
         state   <= TX_IDLE;
         cnt     <= '0;
         bit_cnt <= '0;
      end else begin
         case (state)
            TX_IDLE: begin
               cnt     <= '0;
               bit_cnt <= '0;
               if (i_start) state <= TX_START;   // start while busy is dropped
            end
            TX_START: begin
               cnt <= tick ? '0 : cnt + 1'b1;
               if (tick) state <= TX_SEND;
            end
            TX_SEND: begin
               cnt <= tick ? '0 : cnt + 1'b1;
               if (tick) begin
                  if (bit_cnt == 4'd8) begin
                     state   <= TX_IDLE;
                     bit_cnt <= '0;
                  end else begin
                     bit_cnt <= bit_cnt + 1'b1;
                  end
               end
            end
            default: state <= TX_IDLE;
         endcase
      end
   end

   // stop bit rides above the data byte
   always_ff @(posedge i_clk) begin
      if (state == TX_IDLE && i_start) shreg <= {1'b1, i_data};
      else if (state == TX_SEND && tick) shreg <= {1'b1, shreg[8:1]};
   end

   assign o_busy    = (state != TX_IDLE);
   assign o_uart_tx = (state == TX_START) ? 1'b0 :
                      (state == TX_SEND)  ? shreg[0] :
                                            1'b1;

endmodule

// File: sim/ice_checker.sv
`timescale 1ns/1ps

module ice_checker (
   input  logic                             i_clk,
   input  logic                             i_nrst,
   input  logic                             i_code_wr,
   input  logic [ice_pkg::CODE_AW-1:0]      i_code_addr,
   input  logic [7:0]                       i_code_data,
   input  logic                             i_uart_tx,
   input  logic [8*ice_pkg::LOAD_BYTES-1:0] i_image,       // byte k at bits 8k+7:8k
   input  logic [31:0]                      i_exp_bytes,   // first byte in the low bits
   input  int                               i_exp_cnt,
   output logic                             o_row_done,
   output int                               o_errors
);

   int wr_cnt  = 0;
   int rx_cnt  = 0;
   int wr_errs = 0;
   int rx_errs = 0;

   assign o_errors   = wr_errs + rx_errs;
   assign o_row_done = (wr_cnt == ice_pkg::LOAD_BYTES) && (rx_cnt == i_exp_cnt);

   ////////////////////////////////////////
   // code memory writes from the loader

   always @(negedge i_clk) begin
      if (i_nrst !== 1'b1) begin
         wr_cnt = 0;
      end else if (i_code_wr === 1'b1) begin
         if (wr_cnt >= ice_pkg::LOAD_BYTES) begin
            $display("code write to address %h after the whole image was loaded", i_code_addr);
            wr_errs++;
         end else begin
            if (i_code_addr !== wr_cnt[ice_pkg::CODE_AW-1:0]) begin
               $display("FAILED o_code_addr: got %h, expected %h", i_code_addr, wr_cnt);
               wr_errs++;
            end
            if (i_code_data !== i_image[8*wr_cnt +: 8]) begin
               $display("FAILED o_code_data at %h: got %h, expected %h",
                        wr_cnt, i_code_data, i_image[8*wr_cnt +: 8]);
               wr_errs++;
            end
         end
         wr_cnt++;
      end
   end

   ////////////////////////////////////////
   // uart line, sampled mid-bit

   task automatic receive_frame();
      logic [7:0] rx_byte;
      int         i;
      repeat (ice_pkg::BIT_CLKS/2) @(negedge i_clk);
      if (i_uart_tx !== 1'b0) begin
         $display("start bit on o_uart_tx did not last half a bit period");
         rx_errs++;
      end else begin
         for (i = 0; i < 8; i++) begin
            repeat (ice_pkg::BIT_CLKS) @(negedge i_clk);
            rx_byte[i] = i_uart_tx;   // lsb first
         end
         repeat (ice_pkg::BIT_CLKS) @(negedge i_clk);
         if (i_uart_tx !== 1'b1) begin
            $display("framing error, stop bit on o_uart_tx was low");
            rx_errs++;
         end else if (rx_cnt >= i_exp_cnt) begin
            $display("unexpected extra byte %h sent on o_uart_tx", rx_byte);
            rx_errs++;
         end else if (rx_byte !== i_exp_bytes[8*rx_cnt +: 8]) begin
            $display("FAILED o_uart_tx byte %0d: got %h, expected %h",
                     rx_cnt, rx_byte, i_exp_bytes[8*rx_cnt +: 8]);
            rx_errs++;
         end
         rx_cnt++;
      end
   endtask

   always @(negedge i_nrst) rx_cnt = 0;

   always begin
      @(negedge i_uart_tx);
      if (i_nrst === 1'b1) receive_frame();
   end

endmodule

// File: sim/tb_ice.sv
`timescale 1ns/1ps

module tb_ice;

   localparam int NROWS      = 5;
   localparam int MAX_CYCLES = NROWS * (ice_pkg::LOAD_BYTES + 4) * 10 * ice_pkg::BIT_CLKS * 2;

   logic                             clk;
   logic                             nrst;
   logic                             uart_rx;
   logic [7:0]                       code_rdata;
   logic                             uart_tx;
   logic                             code_wr;
   logic [ice_pkg::CODE_AW-1:0]      code_addr;
   logic [7:0]                       code_wdata;
   logic [7:0]                       mem [2**ice_pkg::CODE_AW];
   logic [8*ice_pkg::LOAD_BYTES-1:0] tbl_image [NROWS];
   logic [31:0]                      tbl_exp [NROWS];
   int                               tbl_cnt [NROWS];
   string                            tbl_name [NROWS];
   logic [8*ice_pkg::LOAD_BYTES-1:0] cur_image;
   logic [31:0]                      cur_exp;
   int                               cur_cnt;
   logic                             row_done;
   int                               errors;
   int                               cycles;
   logic [7:0]                       prog [ice_pkg::LOAD_BYTES];   // row being assembled
   int                               wp;

   ice_top i_dut (
      .i_clk(clk), .i_nrst(nrst), .i_uart_rx(uart_rx), .i_code_data(code_rdata),
      .o_uart_tx(uart_tx), .o_code_wr(code_wr), .o_code_addr(code_addr),
      .o_code_data(code_wdata)
   );

   ice_checker i_checker (
      .i_clk(clk), .i_nrst(nrst), .i_code_wr(code_wr), .i_code_addr(code_addr),
      .i_code_data(code_wdata), .i_uart_tx(uart_tx), .i_image(cur_image),
      .i_exp_bytes(cur_exp), .i_exp_cnt(cur_cnt), .o_row_done(row_done), .o_errors(errors)
   );

   initial begin
      clk = 1'b0;
      forever #20 clk = ~clk;
   end

   // code memory, one cycle read latency
   always @(posedge clk) begin
      if (code_wr === 1'b1) mem[code_addr] <= code_wdata;
      code_rdata <= mem[code_addr];
   end

   ////////////////////////////////////////
   // program assembly

   task automatic start_prog();
      int i;
      for (i = 0; i < ice_pkg::LOAD_BYTES; i += 2) begin
         prog[i]   = ice_pkg::OP_SJMP;
         prog[i+1] = 8'hFE;   // jump to itself
      end
      wp = 0;
   endtask

   // one instruction of n bytes, first byte on top
   task automatic put(input int n, input logic [23:0] ins);
      int i;
      for (i = 0; i < n; i++) begin
         prog[wp] = ins[23-8*i -: 8];
         wp++;
      end
   endtask

   task automatic store_row(input int row, input string name, input logic [31:0] exp_b,
                            input int cnt);
      int i;
      for (i = 0; i < ice_pkg::LOAD_BYTES; i++) begin
         tbl_image[row][8*i +: 8] = prog[i];
      end
      tbl_name[row] = name;
      tbl_exp[row]  = exp_b;
      tbl_cnt[row]  = cnt;
   endtask

   task automatic send_and_halt();
      put(3, {ice_pkg::OP_MOVDP, ice_pkg::TX_DATA_ADDR});
      put(1, {ice_pkg::OP_MOVXDA, 16'h0});
      put(2, {ice_pkg::OP_SJMP, 8'hFE, 8'h0});
   endtask

   task automatic subb_row(input int row, input logic [7:0] x, input logic [7:0] y,
                           input logic [7:0] w, input string name);
      int         c1;
      int         c2;
      logic [7:0] d1;
      logic [7:0] d2;
      start_prog();
      put(1, {ice_pkg::OP_CLRC, 16'h0});
      put(2, {ice_pkg::OP_MOVAI, x, 8'h0});
      put(2, {ice_pkg::OP_SUBBAI, y, 8'h0});
      put(2, {ice_pkg::OP_SUBBAI, w, 8'h0});
      put(3, {ice_pkg::OP_MOVDP, ice_pkg::TX_DATA_ADDR});
      put(2, {ice_pkg::OP_JC, 8'h03, 8'h0});   // over send and halt
      put(1, {ice_pkg::OP_MOVXDA, 16'h0});
      put(2, {ice_pkg::OP_SJMP, 8'hFE, 8'h0});
      put(2, {ice_pkg::OP_XRLAI, 8'hFF, 8'h0});   // borrow path inverts
      send_and_halt();
      // borrow whenever subtrahend plus borrow in exceeds A
      c1 = (x < y);
      d1 = x - y;
      c2 = (int'(d1) < int'(w) + c1);
      d2 = d1 - w - c1;
      store_row(row, name, {24'h0, (c2 != 0) ? ~d2 : d2}, 1);
   endtask

   task automatic build_table();
      logic [7:0] x;
      logic [7:0] y;
      logic [7:0] z;
      logic [7:0] t;
      logic       cy;
      logic       nb;
      int         i;
      x = 8'($urandom);
      y = 8'($urandom);
      z = 8'($urandom);
      start_prog();
      put(2, {ice_pkg::OP_MOVAI, x, 8'h0});
      put(2, {ice_pkg::OP_ADDAI, y, 8'h0});
      put(2, {ice_pkg::OP_XRLAI, z, 8'h0});
      send_and_halt();
      t = x + y;
      store_row(0, "add and xrl", {24'h0, t ^ z}, 1);

      x = 8'($urandom) | 8'h80;   // keeps y at least 3 below x
      y = 8'($urandom % 126);
      subb_row(1, x, y, 8'h00, "subb without borrow");
      subb_row(2, y, x, 8'hFF, "subb with borrow");

      x = 8'($urandom);
      start_prog();
      put(2, {ice_pkg::OP_MOVRI | 8'd1, x, 8'h0});
      put(2, {ice_pkg::OP_MOVRI, 8'd4, 8'h0});       // four bytes
      put(3, {ice_pkg::OP_MOVDP, ice_pkg::TX_STAT_ADDR});
      put(1, {ice_pkg::OP_MOVXAD, 16'h0});
      put(2, {ice_pkg::OP_JNZ, 8'hFD, 8'h0});        // poll busy
      put(3, {ice_pkg::OP_MOVDP, ice_pkg::TX_DATA_ADDR});
      put(1, {ice_pkg::OP_MOVAR | 8'd1, 16'h0});
      put(1, {ice_pkg::OP_MOVXDA, 16'h0});
      put(1, {ice_pkg::OP_INCR | 8'd1, 16'h0});
      put(1, {ice_pkg::OP_MOVAR, 16'h0});
      put(1, {ice_pkg::OP_DECA, 16'h0});
      put(1, {ice_pkg::OP_MOVRA, 16'h0});
      put(2, {ice_pkg::OP_JNZ, 8'hEF, 8'h0});        // back to the status dptr
      put(2, {ice_pkg::OP_SJMP, 8'hFE, 8'h0});
      store_row(3, "polled transmit loop", {8'(x + 3), 8'(x + 2), 8'(x + 1), x}, 4);

      x = 8'($urandom) | 8'h40;   // bit 6 set so the clr c matters
      start_prog();
      put(2, {ice_pkg::OP_MOVAI, x, 8'h0});
      put(1, {ice_pkg::OP_CLRC, 16'h0});
      put(1, {ice_pkg::OP_RLC, 16'h0});
      put(1, {ice_pkg::OP_RLC, 16'h0});
      put(1, {ice_pkg::OP_CLRC, 16'h0});
      put(1, {ice_pkg::OP_RLC, 16'h0});
      send_and_halt();
      t = x;
      cy = 1'b0;
      for (i = 0; i < 3; i++) begin
         if (i == 2) cy = 1'b0;
         nb = t[7];
         t = {t[6:0], cy};
         cy = nb;
      end
      store_row(4, "rlc through carry", {24'h0, t}, 1);
   endtask

   ////////////////////////////////////////
   // uart driver and run

   task automatic send_byte(input logic [7:0] b);
      int i;
      uart_rx <= 1'b0;
      repeat (ice_pkg::BIT_CLKS) @(posedge clk);
      for (i = 0; i < 8; i++) begin
         uart_rx <= b[i];
         repeat (ice_pkg::BIT_CLKS) @(posedge clk);
      end
      uart_rx <= 1'b1;
      repeat (ice_pkg::BIT_CLKS) @(posedge clk);
   endtask

   initial begin
      cycles = 0;
      while (cycles < MAX_CYCLES) begin
         @(posedge clk);
         cycles++;
      end
      $display("timeout after %0d cycles, the expected bytes never all arrived", cycles);
      $display("Simulation failed");
      $finish;
   end

   initial begin
      int i;
      int row;
      int k;
      int err_before;
      int failed_rows;
      nrst       = 1'b0;
      uart_rx    = 1'b1;
      code_rdata = 8'h00;
      cur_image  = '0;
      cur_exp    = '0;
      cur_cnt    = 0;
      void'($urandom(28));
      for (i = 0; i < 2**ice_pkg::CODE_AW; i++) begin
         mem[i] = i[7:0] ^ {i[8], i[8], 6'h2A};
      end
      build_table();
      failed_rows = 0;
      for (row = 0; row < NROWS; row++) begin
         @(posedge clk);
         err_before = errors;
         cur_image <= tbl_image[row];
         cur_exp   <= tbl_exp[row];
         cur_cnt   <= tbl_cnt[row];
         nrst      <= 1'b0;
         repeat (4) @(posedge clk);
         nrst <= 1'b1;
         repeat (2) @(posedge clk);
         for (k = 0; k < ice_pkg::LOAD_BYTES; k++) begin
            send_byte(tbl_image[row][8*k +: 8]);
         end
         while (row_done !== 1'b1) @(posedge clk);
         repeat (ice_pkg::BIT_CLKS) @(posedge clk);   // let the stop bit end
         if (errors == err_before) begin
            $display("test %0d %s: ok", row, tbl_name[row]);
         end else begin
            $display("test %0d %s: %0d errors", row, tbl_name[row], errors - err_before);
            failed_rows++;
         end
      end
      $display("%0d tests, %0d ok, %0d with errors, %0d errors in total",
               NROWS, NROWS - failed_rows, failed_rows, errors);
      if (errors == 0 && failed_rows == 0) begin
         $display("Simulation passed");
      end else begin
         $display("Simulation failed");
      end
      $finish;
   end

endmodule
